//--- filelist.f
rtl/tcdm_pkg.sv
rtl/tcdm_intf.sv
rtl/tcdm_apb_regs.sv
rtl/tcdm_arb_ctrl.sv
rtl/tcdm_xbar_datapath.sv
rtl/tcdm_bank.sv
rtl/tcdm_top.sv
bench/tcdm_checker.sv
bench/tb_tcdm.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass message in the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_tcdm \
  -f filelist.f -o tb_tcdm

./obj_dir/tb_tcdm 2>&1 | tee sim.log

grep -qF '*** PASSED ***' sim.log

//--- bench/tb_tcdm.sv
// testbench with clock, reset, random core and apb traffic, memory and arbiter model, watchdog
`timescale 1ns/1ps

module tb_tcdm import tcdm_pkg::*; ();

  localparam int unsigned N_CORES      = 4;
  localparam int unsigned N_BANKS      = 4;
  localparam int unsigned BANK_DEPTH   = 16;
  localparam int unsigned N_WORDS      = 16;   // small range, many bank conflicts
  localparam int unsigned PHASE_CYCLES = 300;
  localparam int unsigned CLK_PERIOD   = 10;
  localparam int unsigned MAX_CYCLES   = 3 * PHASE_CYCLES + 400;  // margin for drain and apb

  logic                           clk;
  logic                           rst_n;
  logic [N_CORES-1:0]             core_req;
  logic [N_CORES-1:0][ADDR_W-1:0] core_add;
  logic [N_CORES-1:0]             core_wen;
  logic [N_CORES-1:0][DATA_W-1:0] core_wdata;
  logic [N_CORES-1:0][BE_W-1:0]   core_be;
  logic [N_CORES-1:0]             core_gnt;
  logic [N_CORES-1:0]             core_r_valid;
  logic [N_CORES-1:0][DATA_W-1:0] core_r_rdata;
  logic                           psel;
  logic                           penable;
  logic                           pwrite;
  logic [ADDR_W-1:0]              paddr;
  logic [DATA_W-1:0]              pwdata;
  logic [DATA_W-1:0]              prdata;
  logic                           pready;
  logic                           pslverr;

  // reference model state
  integer             seed;
  logic [DATA_W-1:0]  model_mem [N_WORDS];
  logic [DATA_W-1:0]  exp_rdata [N_CORES];
  int unsigned        rr_ptr [N_BANKS];
  int unsigned        wait_cnt [N_CORES];
  int unsigned        conflict_cnt;
  logic [N_CORES-1:0] prev_gnt;
  arb_policy_e        policy_model;
  string              phase_name;

  tcdm_top #(.N_CORES(N_CORES), .N_BANKS(N_BANKS), .BANK_DEPTH(BANK_DEPTH)) DUT (
    .clk_i(clk), .rst_ni(rst_n),
    .core_req_i(core_req), .core_add_i(core_add), .core_wen_i(core_wen),
    .core_wdata_i(core_wdata), .core_be_i(core_be), .core_gnt_o(core_gnt),
    .core_r_valid_o(core_r_valid), .core_r_rdata_o(core_r_rdata),
    .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr),
    .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(MAX_CYCLES * CLK_PERIOD);
    $display("ERROR: watchdog expired after %0d cycles", MAX_CYCLES);
    stop_with_failure();
  end

  task automatic stop_with_failure();
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic fail_plain(input string msg);
    $display("ERROR in %s: %s", phase_name, msg);
    stop_with_failure();
  endtask

  task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected %h, actual %h", phase_name, name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_grant(input string name, input logic [N_CORES-1:0] exp,
                             input logic [N_CORES-1:0] act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected %b, actual %b", phase_name, name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_reg(input string name, input logic [DATA_W-1:0] exp,
                           input logic [DATA_W-1:0] act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected %h, actual %h", phase_name, name, exp, act);
      stop_with_failure();
    end
  endtask

  // one setup and one access phase, pready is always high
  task automatic apb_access(input logic wr, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata,
                            output logic [DATA_W-1:0] rdata, output logic err);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    rdata   = prdata;
    err     = pslverr;
    if (pready !== 1'b1) fail_plain("pready was not high in the access phase");
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic new_request(input int c, input bit issue_new);
    logic [31:0] r;
    r = $random(seed);
    core_req[c]         = issue_new && (r[1:0] != 2'b00);
    core_wen[c]         = r[6];
    core_add[c]         = ADDR_W'(r[5:2]) << 2;
    core_add[c][TS_BIT] = r[6] && (r[8:7] == 2'b00);  // one read in four is a test-and-set
    core_wdata[c]       = $random(seed);
    core_be[c]          = r[12:9];
  endtask

  // one bus cycle: drive, check last responses, predict grants, update model
  task automatic step(input bit issue_new);
    logic [N_CORES-1:0] exp_gnt;
    logic [N_CORES-1:0] hit;
    int unsigned        w;
    int unsigned        idx;
    bit                 found;
    @(posedge clk);
    #1;
    for (int c = 0; c < N_CORES; c++) begin
      if (!core_req[c] || prev_gnt[c]) new_request(c, issue_new);  // denied ones hold
    end
    @(negedge clk);
    check_grant("r_valid", prev_gnt, core_r_valid);
    for (int c = 0; c < N_CORES; c++) begin
      if (prev_gnt[c]) check_data($sformatf("r_rdata core %0d", c), exp_rdata[c], core_r_rdata[c]);
    end
    exp_gnt = '0;
    for (int b = 0; b < N_BANKS; b++) begin
      hit = '0;
      for (int c = 0; c < N_CORES; c++) begin
        if (core_req[c] && (core_add[c][5:2] % N_BANKS == b)) hit[c] = 1'b1;
      end
      found = 1'b0;
      for (int k = 0; k < N_CORES; k++) begin
        idx = (policy_model == ARB_FIXED_PRIO) ? k : (rr_ptr[b] + k) % N_CORES;
        if (hit[idx] && !found) begin
          exp_gnt[idx] = 1'b1;
          found        = 1'b1;
          if (policy_model == ARB_ROUND_ROBIN) rr_ptr[b] = (idx + 1) % N_CORES;
        end
      end
    end
    check_grant("gnt", exp_gnt, core_gnt);
    if (|(core_req & ~exp_gnt)) conflict_cnt++;
    for (int c = 0; c < N_CORES; c++) begin
      w = core_add[c][5:2];
      if (core_req[c] && !exp_gnt[c]) begin
        wait_cnt[c]++;
        if (policy_model == ARB_ROUND_ROBIN && wait_cnt[c] > N_CORES - 1)
          fail_plain($sformatf("core %0d waited more than %0d cycles", c, N_CORES - 1));
      end else begin
        wait_cnt[c] = 0;
      end
      if (exp_gnt[c] && !core_wen[c]) begin
        exp_rdata[c] = '0;   // writes answer with zero
        for (int i = 0; i < BE_W; i++) begin
          if (core_be[c][i]) model_mem[w][8*i +: 8] = core_wdata[c][8*i +: 8];
        end
      end else if (exp_gnt[c]) begin
        exp_rdata[c] = model_mem[w];
        if (core_add[c][TS_BIT]) model_mem[w] = '1;
      end
    end
    prev_gnt = exp_gnt;
  endtask

  task automatic drain();
    step(1'b0);
    while (|core_req || |prev_gnt) step(1'b0);
  endtask

  task automatic run_phase(input arb_policy_e pol, input string name);
    logic [DATA_W-1:0] rd;
    logic              err;
    phase_name = name;
    apb_access(1'b1, APB_CTRL_ADDR, DATA_W'(pol), rd, err);
    if (err) fail_plain("pslverr on write of the policy register");
    policy_model = pol;
    apb_access(1'b0, APB_CTRL_ADDR, '0, rd, err);
    check_reg("policy readback", DATA_W'(pol), rd);
    for (int c = 0; c < N_CORES; c++) wait_cnt[c] = 0;
    repeat (PHASE_CYCLES) step(1'b1);
    drain();
  endtask

  initial begin
    logic [DATA_W-1:0] rd;
    logic              err;
    seed       = 32'hb196;
    rst_n      = 1'b0;
    core_req   = '0;
    core_add   = '0;
    core_wen   = '0;
    core_wdata = '0;
    core_be    = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    for (int i = 0; i < N_WORDS; i++) model_mem[i] = '0;
    for (int b = 0; b < N_BANKS; b++) rr_ptr[b] = 0;
    prev_gnt     = '0;
    conflict_cnt = 0;
    policy_model = ARB_ROUND_ROBIN;
    phase_name   = "reset";
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    apb_access(1'b0, APB_CTRL_ADDR, '0, rd, err);
    check_reg("policy after reset", DATA_W'(ARB_ROUND_ROBIN), rd);

    run_phase(ARB_ROUND_ROBIN, "round_robin");
    run_phase(ARB_FIXED_PRIO, "fixed_prio");
    run_phase(ARB_ROUND_ROBIN, "round_robin_again");

    phase_name = "apb_regs";
    apb_access(1'b0, APB_CONFLICT_ADDR, '0, rd, err);
    check_reg("contention counter", DATA_W'(conflict_cnt), rd);
    apb_access(1'b0, 32'h8, '0, rd, err);
    if (!err) fail_plain("read of unknown offset 0x8 gave no pslverr");
    apb_access(1'b1, APB_CONFLICT_ADDR, 32'h1234, rd, err);
    if (!err) fail_plain("write to the read-only counter gave no pslverr");
    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- bench/tcdm_checker.sv
// bound assertions on the core grant and response handshake
`timescale 1ns/1ps

module tcdm_checker #(
  parameter int unsigned N_CORES = 4
) (
  input logic               clk_i,
  input logic               rst_ni,
  input logic [N_CORES-1:0] req_i,
  input logic [N_CORES-1:0] gnt_i,
  input logic [N_CORES-1:0] r_valid_i
);

  for (genvar c = 0; c < N_CORES; c++) begin : g_core
    // response exactly one cycle after a grant, never otherwise
    a_rsp_after_gnt : assert property (@(posedge clk_i) disable iff (!rst_ni)
      gnt_i[c] |=> r_valid_i[c]) else $error("core %0d: grant without response", c);
    a_rsp_has_gnt : assert property (@(posedge clk_i) disable iff (!rst_ni)
      r_valid_i[c] |-> $past(gnt_i[c])) else $error("core %0d: response without grant", c);
    a_gnt_has_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
      gnt_i[c] |-> req_i[c]) else $error("core %0d: grant without request", c);
    a_req_held : assert property (@(posedge clk_i) disable iff (!rst_ni)
      req_i[c] && !gnt_i[c] |=> req_i[c]) else $error("core %0d: denied request dropped", c);
  end

endmodule

bind tcdm_top tcdm_checker #(.N_CORES(N_CORES)) i_checker (
  .clk_i     ( clk_i          ),
  .rst_ni    ( rst_ni         ),
  .req_i     ( core_req_i     ),
  .gnt_i     ( core_gnt_o     ),
  .r_valid_i ( core_r_valid_o )
);

//--- rtl/tcdm_top.sv
// tcdm subsystem top with plain core and apb ports, interface arrays and instances
`timescale 1ns/1ps

module tcdm_top import tcdm_pkg::*; #(
  parameter int unsigned N_CORES    = 4,
  parameter int unsigned N_BANKS    = 4,
  parameter int unsigned BANK_DEPTH = 16
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic [N_CORES-1:0]               core_req_i,
  input  logic [N_CORES-1:0][ADDR_W-1:0]   core_add_i,
  input  logic [N_CORES-1:0]               core_wen_i,
  input  logic [N_CORES-1:0][DATA_W-1:0]   core_wdata_i,
  input  logic [N_CORES-1:0][BE_W-1:0]     core_be_i,
  output logic [N_CORES-1:0]               core_gnt_o,
  output logic [N_CORES-1:0]               core_r_valid_o,
  output logic [N_CORES-1:0][DATA_W-1:0]   core_r_rdata_o,
  input  logic                             psel_i,
  input  logic                             penable_i,
  input  logic                             pwrite_i,
  input  logic [ADDR_W-1:0]                paddr_i,
  input  logic [DATA_W-1:0]                pwdata_i,
  output logic [DATA_W-1:0]                prdata_o,
  output logic                             pready_o,
  output logic                             pslverr_o
);

  localparam int unsigned ID_W = id_width(N_CORES);

  arb_policy_e                  policy;
  logic                         conflict;
  logic [N_CORES-1:0]           arb_req;
  logic [N_CORES-1:0][ADDR_W-1:0] arb_add;
  logic [N_CORES-1:0]           arb_gnt;
  logic [N_BANKS-1:0]           bank_req;
  logic [N_BANKS-1:0][ID_W-1:0] winner;

  tcdm_core_intf                    core_if [N_CORES-1:0] ();
  tcdm_bank_intf #(.ID_W(ID_W))     bank_if [N_BANKS-1:0] ();

  for (genvar c = 0; c < N_CORES; c++) begin : g_core_ports
    assign core_if[c].req    = core_req_i[c];
    assign core_if[c].add    = core_add_i[c];
    assign core_if[c].wen    = core_wen_i[c];
    assign core_if[c].wdata  = core_wdata_i[c];
    assign core_if[c].be     = core_be_i[c];
    assign core_gnt_o[c]     = core_if[c].gnt;
    assign core_r_valid_o[c] = core_if[c].r_valid;
    assign core_r_rdata_o[c] = core_if[c].r_rdata;
  end

  tcdm_apb_regs i_apb_regs (
    .clk_i, .rst_ni, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .conflict_i ( conflict ),
    .policy_o   ( policy   )
  );

  tcdm_arb_ctrl #(.N_CORES(N_CORES), .N_BANKS(N_BANKS)) i_arb_ctrl (
    .clk_i, .rst_ni,
    .policy_i   ( policy   ),
    .req_i      ( arb_req  ),
    .add_i      ( arb_add  ),
    .gnt_o      ( arb_gnt  ),
    .bank_req_o ( bank_req ),
    .winner_o   ( winner   ),
    .conflict_o ( conflict )
  );

  tcdm_xbar_datapath #(.N_CORES(N_CORES), .N_BANKS(N_BANKS)) i_xbar_datapath (
    .cores      ( core_if  ),
    .banks      ( bank_if  ),
    .gnt_i      ( arb_gnt  ),
    .bank_req_i ( bank_req ),
    .winner_i   ( winner   ),
    .req_o      ( arb_req  ),
    .add_o      ( arb_add  )
  );

  for (genvar b = 0; b < N_BANKS; b++) begin : g_bank
    tcdm_bank #(.BANK_DEPTH(BANK_DEPTH), .ID_W(ID_W)) i_bank (
      .clk_i, .rst_ni,
      .bus ( bank_if[b] )
    );
  end

endmodule

//--- rtl/tcdm_bank.sv
// single memory bank with byte-enable writes, test-and-set and registered response
`timescale 1ns/1ps

module tcdm_bank import tcdm_pkg::*; #(
  parameter int unsigned BANK_DEPTH = 16,
  parameter int unsigned ID_W       = 2
) (
  input logic         clk_i,
  input logic         rst_ni,
  tcdm_bank_intf.bank bus
);

  localparam int unsigned IDX_W = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;

  logic [DATA_W-1:0] mem [BANK_DEPTH];
  logic [IDX_W-1:0]  idx;
  logic              r_valid_q;
  logic [DATA_W-1:0] r_rdata_q;
  logic [ID_W-1:0]   r_id_q;

  assign idx = bus.row[IDX_W-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem       <= '{default: '0};
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= bus.req;   // every request is accepted
      if (bus.req && bus.ts) begin
        mem[idx] <= '1;       // lock taken, old word goes back
      end else if (bus.req && !bus.wen) begin
        for (int i = 0; i < BE_W; i++) begin
          if (bus.be[i]) mem[idx][8*i +: 8] <= bus.wdata[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      r_id_q    <= bus.id;
      r_rdata_q <= bus.wen ? mem[idx] : '0;  // writes answer with zero
    end
  end

  assign bus.r_valid = r_valid_q;
  assign bus.r_rdata = r_rdata_q;
  assign bus.r_id    = r_id_q;

endmodule

//--- rtl/tcdm_xbar_datapath.sv
// request muxing toward the banks and response routing back to the cores
`timescale 1ns/1ps

module tcdm_xbar_datapath import tcdm_pkg::*; #(
  parameter int unsigned N_CORES = 4,
  parameter int unsigned N_BANKS = 4,
  localparam int unsigned ID_W   = id_width(N_CORES)
) (
  tcdm_core_intf.xbar                    cores [N_CORES-1:0],
  tcdm_bank_intf.xbar                    banks [N_BANKS-1:0],
  input  logic [N_CORES-1:0]             gnt_i,
  input  logic [N_BANKS-1:0]             bank_req_i,
  input  logic [N_BANKS-1:0][ID_W-1:0]   winner_i,
  output logic [N_CORES-1:0]             req_o,
  output logic [N_CORES-1:0][ADDR_W-1:0] add_o
);

  logic [N_CORES-1:0]             core_wen;
  logic [N_CORES-1:0][DATA_W-1:0] core_wdata;
  logic [N_CORES-1:0][BE_W-1:0]   core_be;
  logic [N_CORES-1:0]             core_r_valid;
  logic [N_CORES-1:0][DATA_W-1:0] core_r_rdata;
  logic [N_BANKS-1:0]             bank_r_valid;
  logic [N_BANKS-1:0][DATA_W-1:0] bank_r_rdata;
  logic [N_BANKS-1:0][ID_W-1:0]   bank_r_id;

  // flatten core side
  for (genvar c = 0; c < N_CORES; c++) begin : g_core
    assign req_o[c]         = cores[c].req;
    assign add_o[c]         = cores[c].add;
    assign core_wen[c]      = cores[c].wen;
    assign core_wdata[c]    = cores[c].wdata;
    assign core_be[c]       = cores[c].be;
    assign cores[c].gnt     = gnt_i[c];
    assign cores[c].r_valid = core_r_valid[c];
    assign cores[c].r_rdata = core_r_rdata[c];
  end

  // winner steers each bank
  for (genvar b = 0; b < N_BANKS; b++) begin : g_bank
    assign banks[b].req   = bank_req_i[b];
    assign banks[b].wen   = core_wen[winner_i[b]];
    assign banks[b].row   = bank_row(add_o[winner_i[b]], N_BANKS);
    assign banks[b].wdata = core_wdata[winner_i[b]];
    assign banks[b].be    = core_be[winner_i[b]];
    assign banks[b].ts    = bank_req_i[b] & core_wen[winner_i[b]]
                            & add_o[winner_i[b]][TS_BIT];
    assign banks[b].id    = winner_i[b];
    assign bank_r_valid[b] = banks[b].r_valid;
    assign bank_r_rdata[b] = banks[b].r_rdata;
    assign bank_r_id[b]    = banks[b].r_id;
  end

  // at most one bank answers a given core
  always_comb begin
    core_r_valid = '0;
    core_r_rdata = '0;
    for (int b = 0; b < N_BANKS; b++) begin
      if (bank_r_valid[b]) begin
        core_r_valid[bank_r_id[b]] = 1'b1;
        core_r_rdata[bank_r_id[b]] = bank_r_rdata[b];
      end
    end
  end

endmodule

//--- rtl/tcdm_arb_ctrl.sv
// per-bank arbitration with round-robin pointers, core grants and bank winner selects
`timescale 1ns/1ps

module tcdm_arb_ctrl import tcdm_pkg::*; #(
  parameter int unsigned N_CORES = 4,
  parameter int unsigned N_BANKS = 4,
  localparam int unsigned ID_W   = id_width(N_CORES)
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  arb_policy_e                       policy_i,
  input  logic [N_CORES-1:0]                req_i,
  input  logic [N_CORES-1:0][ADDR_W-1:0]    add_i,
  output logic [N_CORES-1:0]                gnt_o,
  output logic [N_BANKS-1:0]                bank_req_o,
  output logic [N_BANKS-1:0][ID_W-1:0]      winner_o,
  output logic                              conflict_o
);

  logic [N_BANKS-1:0][N_CORES-1:0] bank_hit;   // requesters per bank
  logic [N_BANKS-1:0][ID_W-1:0]    rr_ptr_q;

  always_comb begin
    logic        found;
    int unsigned idx;
    bank_hit = '0;
    for (int c = 0; c < N_CORES; c++) begin
      if (req_i[c]) bank_hit[bank_sel(add_i[c], N_BANKS)][c] = 1'b1;
    end

    for (int b = 0; b < N_BANKS; b++) begin
      bank_req_o[b] = |bank_hit[b];
      winner_o[b]   = '0;
      found         = 1'b0;
      for (int k = 0; k < N_CORES; k++) begin
        // fixed priority scans from core 0, round-robin from the pointer
        if (policy_i == ARB_FIXED_PRIO) idx = k;
        else idx = (int'(rr_ptr_q[b]) + k) % N_CORES;
        if (bank_hit[b][idx] && !found) begin
          winner_o[b] = ID_W'(idx);
          found       = 1'b1;
        end
      end
    end

    for (int c = 0; c < N_CORES; c++) begin
      gnt_o[c] = req_i[c] && (winner_o[bank_sel(add_i[c], N_BANKS)] == ID_W'(c));
    end
    conflict_o = |(req_i & ~gnt_o);   // somebody lost this cycle
  end

  // pointer moves one past the winner of each served bank
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_ptr_q <= '0;
    end else if (policy_i == ARB_ROUND_ROBIN) begin
      for (int b = 0; b < N_BANKS; b++) begin
        if (bank_req_o[b]) rr_ptr_q[b] <= ID_W'((winner_o[b] + 1) % N_CORES);
      end
    end
  end

endmodule

//--- rtl/tcdm_apb_regs.sv
// apb slave with the arbitration policy register and the contention counter
`timescale 1ns/1ps

module tcdm_apb_regs import tcdm_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [ADDR_W-1:0] paddr_i,
  input  logic [DATA_W-1:0] pwdata_i,
  output logic [DATA_W-1:0] prdata_o,
  output logic              pready_o,
  output logic              pslverr_o,
  input  logic              conflict_i,
  output arb_policy_e       policy_o
);

  arb_policy_e       policy_q;
  logic [DATA_W-1:0] conflict_cnt_q;
  logic              access;
  logic              is_ctrl;
  logic              is_cnt;

  assign access  = psel_i & penable_i;   // access phase, always one cycle
  assign is_ctrl = (paddr_i == APB_CTRL_ADDR);
  assign is_cnt  = (paddr_i == APB_CONFLICT_ADDR);

  assign pready_o  = 1'b1;
  assign pslverr_o = access & (~(is_ctrl | is_cnt) | (is_cnt & pwrite_i));
  assign policy_o  = policy_q;

  always_comb begin
    prdata_o = '0;
    if (is_ctrl) prdata_o = DATA_W'(policy_q);
    else if (is_cnt) prdata_o = conflict_cnt_q;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      policy_q <= ARB_ROUND_ROBIN;
    end else if (access && pwrite_i && is_ctrl) begin
      policy_q <= arb_policy_e'(pwdata_i[0]);  // new policy from next cycle on
    end
  end

  // saturating contention counter
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      conflict_cnt_q <= '0;
    end else if (conflict_i && (conflict_cnt_q != '1)) begin
      conflict_cnt_q <= conflict_cnt_q + 1'b1;
    end
  end

endmodule

//--- rtl/tcdm_intf.sv
// core-side and bank-side tcdm interfaces with their modports
`timescale 1ns/1ps

interface tcdm_core_intf import tcdm_pkg::*; ();
  logic              req;
  logic [ADDR_W-1:0] add;
  logic              wen;   // low means write
  logic [DATA_W-1:0] wdata;
  logic [BE_W-1:0]   be;
  logic              gnt;
  logic              r_valid;
  logic [DATA_W-1:0] r_rdata;

  modport core (output req, add, wen, wdata, be, input gnt, r_valid, r_rdata);
  modport xbar (input req, add, wen, wdata, be, output gnt, r_valid, r_rdata);
endinterface

interface tcdm_bank_intf import tcdm_pkg::*; #(
  parameter int unsigned ID_W = 2
) ();
  logic              req;
  logic              wen;
  logic [ROW_W-1:0]  row;
  logic [DATA_W-1:0] wdata;
  logic [BE_W-1:0]   be;
  logic              ts;    // test-and-set read
  logic [ID_W-1:0]   id;
  logic              r_valid;
  logic [DATA_W-1:0] r_rdata;
  logic [ID_W-1:0]   r_id;

  modport xbar (output req, wen, row, wdata, be, ts, id, input r_valid, r_rdata, r_id);
  modport bank (input req, wen, row, wdata, be, ts, id, output r_valid, r_rdata, r_id);
endinterface

//--- rtl/tcdm_pkg.sv
// widths, test-and-set bit, arbitration policy type, apb offsets, address field helpers
package tcdm_pkg;

  parameter int unsigned ADDR_W = 32;
  parameter int unsigned DATA_W = 32;
  parameter int unsigned BE_W   = DATA_W / 8;
  parameter int unsigned TS_BIT = 20;
  parameter int unsigned ROW_W  = TS_BIT - 2; // widest row field, banks use the low bits

  typedef enum logic {
    ARB_ROUND_ROBIN = 1'b0,
    ARB_FIXED_PRIO  = 1'b1
  } arb_policy_e;

  parameter logic [ADDR_W-1:0] APB_CTRL_ADDR     = 32'h0000_0000;
  parameter logic [ADDR_W-1:0] APB_CONFLICT_ADDR = 32'h0000_0004;

  // word-interleaved, bank count is a power of two
  function automatic int unsigned bank_sel(input logic [ADDR_W-1:0] add,
                                           input int unsigned n_banks);
    return (add >> 2) % n_banks;
  endfunction

  // row above the bank bits, test-and-set bit excluded
  function automatic logic [ROW_W-1:0] bank_row(input logic [ADDR_W-1:0] add,
                                                input int unsigned n_banks);
    logic [ADDR_W-1:0] word;
    word = ADDR_W'(add[TS_BIT-1:2]) / n_banks;
    return word[ROW_W-1:0];
  endfunction

  // core index width, at least one bit
  function automatic int unsigned id_width(input int unsigned n_cores);
    return (n_cores > 1) ? $clog2(n_cores) : 1;
  endfunction

endpackage
